// ==== project.f ====
verilog/rule_pkg.sv
verilog/buffer_pkg.sv
verilog/rule_dedup.sv
verilog/rule_fifo.sv
verilog/rule_merge.sv
verilog/rule_reduction.sv
verif/rule_reduction_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the rule reduction testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --top-module rule_reduction_tb -f project.f \
    --Mdir "$BUILD_DIR" -o rule_reduction_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/rule_reduction_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    exit 1
fi
exit 0

// ==== verif/rule_reduction_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module rule_reduction_tb;

    import rule_pkg::*;

    localparam int FILTER_BEATS   = 9;
    localparam int N_PKTS         = 6;
    localparam int MAX_PKT_LEN    = 12;
    localparam int RR_BEATS       = 9;
    localparam int BP_MAX_BEATS   = 120;
    localparam int BP_EXTRA_BEATS = 20;
    localparam int TOTAL_BEATS    = FILTER_BEATS + N_PKTS * (MAX_PKT_LEN + 1) + RR_BEATS
                                    + BP_MAX_BEATS + BP_EXTRA_BEATS + 1;
    // four words per group per beat at half output rate plus resets and drains
    localparam int CYCLE_LIMIT    = TOTAL_BEATS * 8 + 1000;

    localparam int READY_HIGH   = 0;
    localparam int READY_LOW    = 1;
    localparam int READY_RANDOM = 2;

    logic                      clk;
    logic                      rst;
    rule_beat_t                rule_data;
    logic                      rule_valid;
    logic                      rule_eop;
    logic                      rule_ready;
    rule_nf_t [NUM_GROUPS-1:0] rule_out;
    logic [NUM_GROUPS-1:0]     rule_out_valid;
    logic [NUM_GROUPS-1:0]     rule_out_ready;

    logic [31:0] lfsr;
    int          ready_mode;
    string       test_name;
    int          errors;
    int          checks;
    int          cycles = 0;

    // expected ids per lane with the packet number in the upper half
    logic [31:0] exp_q [NUM_LANES][$];
    int          rr_log [NUM_GROUPS][$];
    rule_id_t    kept [NUM_LANES];
    int          sent_pkts;
    int          rcv_markers [NUM_GROUPS];

    rule_reduction dut_i (
        .clk            (clk),
        .rst            (rst),
        .rule_data      (rule_data),
        .rule_valid     (rule_valid),
        .rule_eop       (rule_eop),
        .rule_ready     (rule_ready),
        .rule_out       (rule_out),
        .rule_out_valid (rule_out_valid),
        .rule_out_ready (rule_out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, expected words never arrived", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // lane number in the top three bits
    function automatic rule_id_t make_id(input int lane, input logic [12:0] low);
        return {lane[2:0], low};
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        errors++;
        $display("FAIL %s: %s expected %h actual %h", test_name, what, exp_v, act_v);
    endtask

    task automatic log_problem(input string msg);
        errors++;
        $display("error in %s: %s", test_name, msg);
    endtask

    task automatic model_accept(input rule_beat_t beat, input logic eop);
        for (int l = 0; l < NUM_LANES; l++) begin
            if (eop) begin
                kept[l] = '0;
            end else if (beat[l] != '0 && beat[l] != kept[l]) begin
                exp_q[l].push_back({sent_pkts[15:0], beat[l]});
                kept[l] = beat[l];
            end
        end
        if (eop) begin
            sent_pkts++;
        end
    endtask

    task automatic check_word(input int g, input rule_nf_t w);
        logic [31:0] head;
        int          lane;
        int          pkt;
        checks++;
        if (w.last) begin
            if (w.data != '0) begin
                report_mismatch($sformatf("group %0d marker data", g), 32'h0,
                                {16'h0, w.data});
            end
            if (rcv_markers[g] >= sent_pkts) begin
                log_problem($sformatf("group %0d sent a marker with no packet open", g));
            end
            // nothing of this packet may still be waiting
            for (int l = g * LANES_PER_GROUP; l < (g + 1) * LANES_PER_GROUP; l++) begin
                if (exp_q[l].size() > 0) begin
                    head = exp_q[l][0];
                    if (int'(head[31:16]) <= rcv_markers[g]) begin
                        report_mismatch($sformatf("group %0d marker", g),
                                        {16'h0, head[15:0]}, {15'h0, w});
                    end
                end
            end
            rcv_markers[g]++;
        end else begin
            lane = int'(w.data[15:13]);
            if (lane / LANES_PER_GROUP != g) begin
                report_mismatch($sformatf("group of id %h", w.data), g, lane / LANES_PER_GROUP);
            end else if (exp_q[lane].size() == 0) begin
                log_problem($sformatf("unexpected id %h on group %0d", w.data, g));
            end else begin
                head = exp_q[lane].pop_front();
                pkt  = int'(head[31:16]);
                if (w.data != head[15:0]) begin
                    report_mismatch($sformatf("lane %0d id", lane), {16'h0, head[15:0]},
                                    {16'h0, w.data});
                end
                if (pkt != rcv_markers[g]) begin
                    report_mismatch($sformatf("packet of id %h", w.data), pkt, rcv_markers[g]);
                end
                rr_log[g].push_back(lane);
            end
        end
    endtask

    // one clock step taken from a point where outputs are stable
    task automatic tick();
        for (int g = 0; g < NUM_GROUPS; g++) begin
            if (rule_out_valid[g] && rule_out_ready[g]) begin
                check_word(g, rule_out[g]);
            end
        end
        @(posedge clk);
        #2;
        case (ready_mode)
            READY_HIGH: rule_out_ready = '1;
            READY_LOW:  rule_out_ready = '0;
            default:    rule_out_ready = NUM_GROUPS'(rand_bits(NUM_GROUPS));
        endcase
    endtask

    task automatic send_beat(input rule_beat_t beat, input logic eop);
        logic took;
        rule_data  = beat;
        rule_eop   = eop;
        rule_valid = 1'b1;
        do begin
            took = rule_ready;
            tick();
        end while (!took);
        rule_valid = 1'b0;
        model_accept(beat, eop);
    endtask

    task automatic wait_drain();
        logic busy;
        busy = 1'b1;
        while (busy) begin
            tick();
            busy = 1'b0;
            for (int l = 0; l < NUM_LANES; l++) begin
                if (exp_q[l].size() != 0) begin
                    busy = 1'b1;
                end
            end
            for (int g = 0; g < NUM_GROUPS; g++) begin
                if (rcv_markers[g] != sent_pkts) begin
                    busy = 1'b1;
                end
            end
        end
        // stray extra words show up here
        repeat (8) tick();
        checks++;
        if (rule_out_valid != '0) begin
            log_problem("output still valid after every expected word arrived");
        end
    endtask

    task automatic apply_reset();
        rst        = 1'b1;
        rule_valid = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            exp_q[l].delete();
            kept[l] = '0;
        end
        for (int g = 0; g < NUM_GROUPS; g++) begin
            rr_log[g].delete();
            rcv_markers[g] = 0;
        end
        sent_pkts = 0;
    endtask

    task automatic reset_behavior();
        test_name = "reset";
        apply_reset();
        repeat (4) begin
            checks++;
            if (rule_ready !== 1'b1) begin
                report_mismatch("rule_ready", 32'h1, 32'(rule_ready));
            end
            if (rule_out_valid !== '0) begin
                report_mismatch("rule_out_valid", 32'h0, 32'(rule_out_valid));
            end
            tick();
        end
    endtask

    task automatic filtering();
        rule_beat_t a;
        rule_beat_t b;
        rule_beat_t junk;
        rule_beat_t zero;
        test_name = "filtering";
        zero      = '0;
        for (int l = 0; l < NUM_LANES; l++) begin
            a[l]    = make_id(l, 13'h0a0 + 13'(l));
            b[l]    = make_id(l, 13'h1b0 + 13'(l));
            junk[l] = make_id(l, 13'(rand_bits(13)));
        end
        send_beat(a, 1'b0);
        send_beat(zero, 1'b0);
        send_beat(a, 1'b0);
        send_beat(b, 1'b0);
        send_beat(b, 1'b0);
        send_beat(a, 1'b0);
        send_beat(junk, 1'b1);
        // same value again in a new packet
        send_beat(a, 1'b0);
        send_beat(junk, 1'b1);
        wait_drain();
    endtask

    task automatic packet_barrier();
        rule_beat_t beat;
        rule_beat_t prev;
        int         len;
        test_name = "barrier";
        prev      = '0;
        for (int p = 0; p < N_PKTS; p++) begin
            len = 1 + int'(rand_bits(4)) % MAX_PKT_LEN;
            for (int k = 0; k < len; k++) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    case (2'(rand_bits(2)))
                        2'd0:    beat[l] = '0;
                        2'd1:    beat[l] = prev[l];
                        default: beat[l] = make_id(l, 13'(rand_bits(13)));
                    endcase
                end
                send_beat(beat, 1'b0);
                prev = beat;
            end
            send_beat(prev, 1'b1);
        end
        wait_drain();
    endtask

    task automatic round_robin_order();
        rule_beat_t beat;
        int         want;
        test_name = "round robin";
        apply_reset();
        for (int k = 0; k < RR_BEATS - 1; k++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                beat[l] = make_id(l, 13'(k + 1));
            end
            send_beat(beat, 1'b0);
        end
        send_beat(beat, 1'b1);
        wait_drain();
        for (int g = 0; g < NUM_GROUPS; g++) begin
            checks++;
            for (int i = 0; i < rr_log[g].size(); i++) begin
                want = g * LANES_PER_GROUP + i % LANES_PER_GROUP;
                if (rr_log[g][i] != want) begin
                    report_mismatch($sformatf("group %0d grant %0d lane", g, i),
                                    want, rr_log[g][i]);
                end
            end
        end
    endtask

    task automatic back_pressure();
        rule_beat_t beat;
        logic       stalled;
        test_name  = "back-pressure";
        stalled    = 1'b0;
        ready_mode = READY_LOW;
        tick();
        for (int k = 0; k < BP_MAX_BEATS && !stalled; k++) begin
            if (!rule_ready) begin
                stalled = 1'b1;
            end else begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    beat[l] = make_id(l, 13'(k + 1));
                end
                send_beat(beat, 1'b0);
            end
        end
        checks++;
        if (!stalled) begin
            log_problem("rule_ready never fell while the output was held off");
        end
        ready_mode = READY_RANDOM;
        for (int k = 0; k < BP_EXTRA_BEATS; k++) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                beat[l] = make_id(l, 13'(rand_bits(13)));
            end
            send_beat(beat, 1'b0);
        end
        send_beat(beat, 1'b1);
        wait_drain();
        ready_mode = READY_HIGH;
        tick();
    endtask

    initial begin
        rst            = 1'b1;
        rule_data      = '0;
        rule_valid     = 1'b0;
        rule_eop       = 1'b0;
        rule_out_ready = '1;
        ready_mode     = READY_HIGH;
        lfsr           = 32'h88cb9b7a;
        errors         = 0;
        checks         = 0;
        sent_pkts      = 0;
        reset_behavior();
        filtering();
        packet_barrier();
        round_robin_order();
        back_pressure();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/rule_reduction.sv ====
`default_nettype none
`timescale 1ns/1ps

module rule_reduction (
    input  wire                                             clk,
    input  wire                                             rst,
    input  wire rule_pkg::rule_beat_t                       rule_data,
    input  wire                                             rule_valid,
    input  wire                                             rule_eop,
    output logic                                            rule_ready,
    output rule_pkg::rule_nf_t [rule_pkg::NUM_GROUPS-1:0]   rule_out,
    output logic [rule_pkg::NUM_GROUPS-1:0]                 rule_out_valid,
    input  wire [rule_pkg::NUM_GROUPS-1:0]                  rule_out_ready
);

    import rule_pkg::*;

    localparam int LPG = LANES_PER_GROUP;

    logic                            accept;
    logic [NUM_LANES-1:0]            lane_wr;
    rule_nf_t [NUM_LANES-1:0]        lane_word;
    rule_nf_t [NUM_LANES-1:0]        lane_head;
    logic [NUM_LANES-1:0]            lane_not_empty;
    logic [NUM_LANES-1:0]            lane_afull;
    logic [NUM_LANES-1:0]            lane_rd;
    logic [NUM_GROUPS-1:0]           out_wr;
    rule_nf_t [NUM_GROUPS-1:0]       out_word;
    logic [NUM_GROUPS-1:0]           out_afull;

    // any lane near full stalls the whole beat
    assign rule_ready = ~|lane_afull;
    assign accept     = rule_valid && rule_ready;

    for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
        rule_dedup dedup_i (
            .clk       (clk),
            .rst       (rst),
            .lane_id   (rule_data[l]),
            .accept    (accept),
            .eop       (rule_eop),
            .lane_wr   (lane_wr[l]),
            .lane_word (lane_word[l])
        );

        rule_fifo lane_fifo_i (
            .clk         (clk),
            .rst         (rst),
            .wr_en       (lane_wr[l]),
            .wr_data     (lane_word[l]),
            .rd_en       (lane_rd[l]),
            .rd_data     (lane_head[l]),
            .not_empty   (lane_not_empty[l]),
            .almost_full (lane_afull[l])
        );
    end

    for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
        rule_merge merge_i (
            .clk        (clk),
            .rst        (rst),
            .heads      (lane_head[g*LPG +: LPG]),
            .head_valid (lane_not_empty[g*LPG +: LPG]),
            .out_afull  (out_afull[g]),
            .rd_en      (lane_rd[g*LPG +: LPG]),
            .out_wr     (out_wr[g]),
            .out_word   (out_word[g])
        );

        // output side pops straight from the consumer's ready
        rule_fifo out_fifo_i (
            .clk         (clk),
            .rst         (rst),
            .wr_en       (out_wr[g]),
            .wr_data     (out_word[g]),
            .rd_en       (rule_out_ready[g]),
            .rd_data     (rule_out[g]),
            .not_empty   (rule_out_valid[g]),
            .almost_full (out_afull[g])
        );
    end

endmodule

`default_nettype wire

// ==== verilog/rule_merge.sv ====
`default_nettype none
`timescale 1ns/1ps

module rule_merge (
    input  wire                                                  clk,
    input  wire                                                  rst,
    input  wire rule_pkg::rule_nf_t [rule_pkg::LANES_PER_GROUP-1:0] heads,
    input  wire [rule_pkg::LANES_PER_GROUP-1:0]                  head_valid,
    input  wire                                                  out_afull,
    output logic [rule_pkg::LANES_PER_GROUP-1:0]                 rd_en,
    output logic                                                 out_wr,
    output rule_pkg::rule_nf_t                                   out_word
);

    import rule_pkg::*;

    localparam int N = LANES_PER_GROUP;

    logic [N-1:0]   head_last;
    logic [N-1:0]   req;
    logic [N-1:0]   grant;
    logic [N-1:0]   rr_ptr;
    logic [2*N-1:0] req_dbl;
    logic [2*N-1:0] grant_dbl;
    logic           barrier;
    rule_nf_t       grant_word;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            head_last[i] = heads[i].last;
        end
    end

    // markers never request, they wait for the barrier
    assign req     = head_valid & ~head_last & {N{~out_afull}};
    assign barrier = (&(head_valid & head_last)) && !out_afull;

    // round robin, first request at or above the one-hot pointer
    // wrapping around through the upper copy
    assign req_dbl   = {req, req};
    assign grant_dbl = req_dbl & ~(req_dbl - {{N{1'b0}}, rr_ptr});
    assign grant     = grant_dbl[N-1:0] | grant_dbl[2*N-1:N];

    always_ff @(posedge clk) begin
        if (rst) begin
            rr_ptr <= {{(N-1){1'b0}}, 1'b1};
        end else if (|grant) begin
            // next search starts one past the winner
            rr_ptr <= {grant[N-2:0], grant[N-1]};
        end
    end

    always_comb begin
        grant_word = '0;
        for (int i = 0; i < N; i++) begin
            if (grant[i]) begin
                grant_word = heads[i];
            end
        end
    end

    // barrier pops every lane at once
    assign rd_en = barrier ? {N{1'b1}} : grant;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_wr <= 1'b0;
        end else begin
            out_wr <= barrier || (|grant);
        end
    end

    always_ff @(posedge clk) begin
        if (barrier) begin
            out_word.last <= 1'b1;
            out_word.data <= '0;
        end else begin
            out_word <= grant_word;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rule_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module rule_fifo (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     wr_en,
    input  wire rule_pkg::rule_nf_t wr_data,
    input  wire                     rd_en,
    output rule_pkg::rule_nf_t      rd_data,
    output logic                    not_empty,
    output logic                    almost_full
);

    import rule_pkg::*;
    import buffer_pkg::*;

    rule_nf_t               mem [FIFO_DEPTH];
    logic [FIFO_AWIDTH-1:0] wr_ptr;
    logic [FIFO_AWIDTH-1:0] rd_ptr;
    fifo_count_t            count;
    fifo_count_t            count_next;
    logic                   do_rd;

    // a read on an empty fifo does nothing
    assign do_rd = rd_en && not_empty;

    always_comb begin
        count_next = count;
        case ({wr_en, do_rd})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            count       <= '0;
            almost_full <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count       <= count_next;
            almost_full <= count_next >= fifo_count_t'(FIFO_AFULL_TH);
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // show-ahead head word
    assign rd_data   = mem[rd_ptr];
    assign not_empty = count != '0;

endmodule

`default_nettype wire

// ==== verilog/rule_dedup.sv ====
`default_nettype none
`timescale 1ns/1ps

module rule_dedup (
    input  wire                     clk,
    input  wire                     rst,
    input  wire rule_pkg::rule_id_t lane_id,
    input  wire                     accept,
    input  wire                     eop,
    output logic                    lane_wr,
    output rule_pkg::rule_nf_t      lane_word
);

    import rule_pkg::*;

    // last id kept in the current packet
    rule_id_t kept_id;
    logic     keep_id;

    assign keep_id = (lane_id != '0) && (lane_id != kept_id);

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_wr <= 1'b0;
            kept_id <= '0;
        end else begin
            lane_wr <= 1'b0;
            if (accept) begin
                if (eop) begin
                    // marker only, the lane id of this beat is discarded
                    lane_wr <= 1'b1;
                    kept_id <= '0;
                end else if (keep_id) begin
                    lane_wr <= 1'b1;
                    kept_id <= lane_id;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lane_word.last <= eop;
        lane_word.data <= eop ? '0 : lane_id;
    end

endmodule

`default_nettype wire

// ==== verilog/buffer_pkg.sv ====
`default_nettype none

package buffer_pkg;

    localparam int FIFO_DEPTH    = 64;
    localparam int FIFO_AWIDTH   = $clog2(FIFO_DEPTH);

    // 24 spare entries above the threshold absorb in-flight words
    localparam int FIFO_AFULL_TH = FIFO_DEPTH - 24;

    // one extra bit so a full fifo can be counted
    typedef logic [FIFO_AWIDTH:0] fifo_count_t;

endpackage

`default_nettype wire

// ==== verilog/rule_pkg.sv ====
`default_nettype none

package rule_pkg;

    // input beat geometry
    localparam int BEAT_WIDTH      = 128;
    localparam int NUM_LANES       = 8;
    localparam int RULE_AWIDTH     = BEAT_WIDTH / NUM_LANES;

    // lanes are split evenly over the merge units
    localparam int LANES_PER_GROUP = 4;
    localparam int NUM_GROUPS      = NUM_LANES / LANES_PER_GROUP;

    typedef logic [RULE_AWIDTH-1:0] rule_id_t;

    // fifo word, data is zero when last is set
    typedef struct packed {
        logic     last;
        rule_id_t data;
    } rule_nf_t;

    // lane 0 sits in the low bits
    typedef rule_id_t [NUM_LANES-1:0] rule_beat_t;

endpackage

`default_nettype wire
